// File: hdl/sched_geometry_pkg.sv
package sched_geometry_pkg;

    // two bank groups of four banks
    localparam int num_banks       = 8;
    localparam int bank_group_bits = 1;
    localparam int bank_bits       = 2;
    localparam int bank_index_bits = 3;  // {bank group, bank}

    localparam int row_bits   = 8;
    localparam int col_bits   = 4;
    localparam int paddr_bits = 15;  // row | bank group | bank | col, msb to lsb
    localparam int data_bits  = 32;

    // per bank queue
    localparam int queue_depth    = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);

    typedef logic [bank_group_bits-1:0] bank_group_t;
    typedef logic [bank_bits-1:0]       bank_t;
    typedef logic [bank_index_bits-1:0] bank_index_t;
    typedef logic [row_bits-1:0]        row_t;
    typedef logic [col_bits-1:0]        col_t;
    typedef logic [data_bits-1:0]       data_t;
    typedef logic [paddr_bits-1:0]      paddr_t;

    // one queued access, address already split
    typedef struct packed {
        bank_group_t bank_group;
        bank_t       bank;
        row_t        row;
        col_t        col;
        logic        write;  // 0 read, 1 write
        data_t       data;   // only meaningful for writes
    } mem_request_t;

endpackage

// File: hdl/dram_cmd_pkg.sv
package dram_cmd_pkg;

    // same encoding as the controller expects on cmd_out
    typedef enum logic [1:0] {
        cmd_read      = 2'd0,
        cmd_write     = 2'd1,
        cmd_activate  = 2'd2,
        cmd_precharge = 2'd3
    } dram_cmd_t;

    // output register state of the picker
    typedef enum logic {
        idle  = 1'b0,
        issue = 1'b1  // valid_out asserted
    } picker_state_t;

    // cycles a bank is blocked after the command
    localparam int activate_latency  = 8;
    localparam int precharge_latency = 5;

    // wide enough for the longer of the two
    localparam int timer_bits = $clog2(activate_latency + 1);

endpackage

// File: hdl/bank_status_if.sv
`timescale 1ns/10ps

interface bank_status_if;
    import sched_geometry_pkg::*;

    // state per bank, from the tracker
    logic [num_banks-1:0] open;
    row_t [num_banks-1:0] open_row;
    logic [num_banks-1:0] busy;

    // orders from the picker, one cycle each, never both at once
    logic        activate_strobe;
    logic        precharge_strobe;
    bank_index_t order_bank;
    row_t        order_row;  // row to open on activate

    modport tracker (
        output open, open_row, busy,
        input  activate_strobe, precharge_strobe, order_bank, order_row
    );

    modport user (
        input  open, open_row, busy,
        output activate_strobe, precharge_strobe, order_bank, order_row
    );

endinterface

// File: hdl/queue_head_if.sv
`timescale 1ns/10ps

interface queue_head_if;
    import sched_geometry_pkg::*;

    // head entry of every bank queue
    mem_request_t [num_banks-1:0] head;
    logic         [num_banks-1:0] empty;  // head invalid when set

    // one cycle strobe per bank, removes the head
    logic [num_banks-1:0] pop;

    modport producer (
        output head, empty,
        input  pop
    );

    modport consumer (
        input  head, empty,
        output pop
    );

endinterface

// File: hdl/bank_queues.sv
`timescale 1ns/10ps

module bank_queues (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       valid_in,
    input  logic                       write_in,
    input  sched_geometry_pkg::paddr_t addr_in,
    input  sched_geometry_pkg::data_t  data_in,
    output logic                       queue_full,
    queue_head_if.producer             heads
);
    import sched_geometry_pkg::*;

    mem_request_t req;
    bank_index_t  wr_bank;
    logic         push;
    logic [num_banks-1:0] push_bank;

    logic [queue_ptr_bits-1:0] rd_ptr [num_banks];
    logic [queue_ptr_bits-1:0] wr_ptr [num_banks];
    logic [queue_ptr_bits:0]   count  [num_banks];
    logic [num_banks-1:0]      full;

    mem_request_t queue_mem [num_banks][queue_depth];

    // address split, col at the bottom and row at the top
    assign req.col        = addr_in[col_bits-1:0];
    assign req.bank       = addr_in[col_bits +: bank_bits];
    assign req.bank_group = addr_in[col_bits + bank_bits +: bank_group_bits];
    assign req.row        = addr_in[paddr_bits-1 -: row_bits];
    assign req.write      = write_in;
    assign req.data       = data_in;

    assign wr_bank    = {req.bank_group, req.bank};
    assign queue_full = full[wr_bank];  // level for the addressed bank only
    assign push       = valid_in && !queue_full;  // full drops the request

    always_ff @(posedge clk_in) begin
        if (push) begin
            queue_mem[wr_bank][wr_ptr[wr_bank]] <= req;
        end
    end

    for (genvar b = 0; b < num_banks; b++) begin : g_queue
        assign push_bank[b] = push && (wr_bank == bank_index_t'(b));
        assign full[b]      = (count[b] == queue_depth[queue_ptr_bits:0]);

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                rd_ptr[b] <= '0;
                wr_ptr[b] <= '0;
                count[b]  <= '0;
            end else begin
                if (push_bank[b]) wr_ptr[b] <= wr_ptr[b] + 1'b1;  // wraps at depth
                if (heads.pop[b]) rd_ptr[b] <= rd_ptr[b] + 1'b1;
                case ({push_bank[b], heads.pop[b]})
                    2'b10:   count[b] <= count[b] + 1'b1;
                    2'b01:   count[b] <= count[b] - 1'b1;
                    default: count[b] <= count[b];  // none, or push and pop together
                endcase
            end
        end

        assign heads.head[b]  = queue_mem[b][rd_ptr[b]];
        assign heads.empty[b] = (count[b] == '0);
    end

endmodule

// File: hdl/bank_tracker.sv
`timescale 1ns/10ps

module bank_tracker (
    input  logic          clk_in,
    input  logic          rst_in,
    bank_status_if.tracker status
);
    import sched_geometry_pkg::*;
    import dram_cmd_pkg::*;

    logic                  open_q  [num_banks];
    row_t                  row_q   [num_banks];
    logic [timer_bits-1:0] timer_q [num_banks];

    logic [num_banks-1:0] act_hit;
    logic [num_banks-1:0] pre_hit;

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        // order addressed to this bank
        assign act_hit[b] = status.activate_strobe && (status.order_bank == bank_index_t'(b));
        assign pre_hit[b] = status.precharge_strobe && (status.order_bank == bank_index_t'(b));

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                open_q[b]  <= 1'b0;
                row_q[b]   <= '0;
                timer_q[b] <= '0;
            end else if (act_hit[b]) begin
                open_q[b]  <= 1'b1;
                row_q[b]   <= status.order_row;
                timer_q[b] <= timer_bits'(activate_latency);
            end else if (pre_hit[b]) begin
                open_q[b]  <= 1'b0;  // row kept, ignored while closed
                timer_q[b] <= timer_bits'(precharge_latency);
            end else if (timer_q[b] != '0) begin
                timer_q[b] <= timer_q[b] - 1'b1;
            end
        end

        // busy for exactly the latency in cycles after the order edge
        assign status.busy[b]     = (timer_q[b] != '0);
        assign status.open[b]     = open_q[b];
        assign status.open_row[b] = row_q[b];
    end

endmodule

// File: hdl/command_picker.sv
`timescale 1ns/10ps

module command_picker (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic                             cmd_ready,
    queue_head_if.consumer                   heads,
    bank_status_if.user                      status,
    output logic                             valid_out,
    output dram_cmd_pkg::dram_cmd_t          cmd_out,
    output sched_geometry_pkg::bank_group_t  bank_group_out,
    output sched_geometry_pkg::bank_t        bank_out,
    output sched_geometry_pkg::row_t         row_out,
    output sched_geometry_pkg::col_t         col_out,
    output sched_geometry_pkg::data_t        data_out
);
    import sched_geometry_pkg::*;
    import dram_cmd_pkg::*;

    logic                 found;
    bank_index_t          pick_bank;
    mem_request_t         pick;
    dram_cmd_t            next_cmd;
    logic                 issue_now;
    logic                 is_access;
    logic [num_banks-1:0] pop_vec;
    picker_state_t        state;

    // lowest bank with work that is not blocked
    always_comb begin
        found     = 1'b0;
        pick_bank = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (!found && !heads.empty[b] && !status.busy[b]) begin
                found     = 1'b1;
                pick_bank = bank_index_t'(b);
            end
        end
    end

    assign pick = heads.head[pick_bank];

    always_comb begin
        if (!status.open[pick_bank]) begin
            next_cmd = cmd_activate;
        end else if (status.open_row[pick_bank] == pick.row) begin
            next_cmd = pick.write ? cmd_write : cmd_read;  // row hit
        end else begin
            next_cmd = cmd_precharge;  // wrong row open
        end
    end

    assign issue_now = cmd_ready && found;
    assign is_access = (next_cmd == cmd_read) || (next_cmd == cmd_write);

    // only an access retires the head
    always_comb begin
        pop_vec = '0;
        if (issue_now && is_access) pop_vec[pick_bank] = 1'b1;
    end
    assign heads.pop = pop_vec;

    assign status.activate_strobe  = issue_now && (next_cmd == cmd_activate);
    assign status.precharge_strobe = issue_now && (next_cmd == cmd_precharge);
    assign status.order_bank       = pick_bank;
    assign status.order_row        = pick.row;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state          <= idle;
            cmd_out        <= cmd_read;
            bank_group_out <= '0;
            bank_out       <= '0;
            row_out        <= '0;
            col_out        <= '0;
            data_out       <= '0;
        end else begin
            state <= issue_now ? issue : idle;
            if (issue_now) begin  // fields hold between commands
                cmd_out        <= next_cmd;
                bank_group_out <= pick.bank_group;
                bank_out       <= pick.bank;
                row_out        <= pick.row;
                col_out        <= pick.col;
                data_out       <= (next_cmd == cmd_write) ? pick.data : '0;
            end
        end
    end

    assign valid_out = (state == issue);

endmodule

// File: hdl/request_scheduler.sv
`timescale 1ns/10ps

module request_scheduler (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            valid_in,
    input  logic                            write_in,
    input  sched_geometry_pkg::paddr_t      addr_in,
    input  sched_geometry_pkg::data_t       data_in,
    input  logic                            cmd_ready,
    output logic                            queue_full,
    output logic                            valid_out,
    output dram_cmd_pkg::dram_cmd_t         cmd_out,
    output sched_geometry_pkg::bank_group_t bank_group_out,
    output sched_geometry_pkg::bank_t       bank_out,
    output sched_geometry_pkg::row_t        row_out,
    output sched_geometry_pkg::col_t        col_out,
    output sched_geometry_pkg::data_t       data_out
);

    queue_head_if  heads ();
    bank_status_if status ();

    // requests in, one fifo per bank
    bank_queues queues0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .valid_in   (valid_in),
        .write_in   (write_in),
        .addr_in    (addr_in),
        .data_in    (data_in),
        .queue_full (queue_full),
        .heads      (heads.producer)
    );

    // open rows and busy timers, steered by the picker
    bank_tracker tracker0 (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .status (status.tracker)
    );

    command_picker picker0 (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .heads          (heads.consumer),
        .status         (status.user),
        .valid_out      (valid_out),
        .cmd_out        (cmd_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .data_out       (data_out)
    );

endmodule

// File: verification/request_scheduler_tb.sv
`timescale 1ns/10ps

module request_scheduler_tb;
    import sched_geometry_pkg::*;
    import dram_cmd_pkg::*;

    typedef struct packed {
        logic        wr;
        row_t        row;
        bank_group_t bg;
        bank_t       bank;
        col_t        col;
        data_t       data;
        logic        hold;  // keep cmd_ready low
        logic        full;  // queue_full expected
    } stim_t;

    localparam int num_stim = 17;
    localparam int clk_period = 100;

    stim_t stim_table [num_stim] = '{
        '{1'b1, 8'h12, 1'b0, 2'd0, 4'd1,  32'ha5a5_0001, 1'b0, 1'b0},
        '{1'b0, 8'h12, 1'b0, 2'd0, 4'd2,  32'h0,         1'b0, 1'b0},
        '{1'b1, 8'h34, 1'b0, 2'd0, 4'd3,  32'hc3c3_0003, 1'b0, 1'b0},  // row change
        '{1'b0, 8'h34, 1'b0, 2'd0, 4'd4,  32'h0,         1'b0, 1'b0},
        '{1'b0, 8'h40, 1'b1, 2'd3, 4'd5,  32'h0,         1'b0, 1'b0},
        '{1'b1, 8'h40, 1'b1, 2'd3, 4'd6,  32'h1234_5678, 1'b0, 1'b0},
        '{1'b1, 8'h07, 1'b0, 2'd2, 4'd7,  32'hdead_0007, 1'b0, 1'b0},
        '{1'b1, 8'h55, 1'b1, 2'd1, 4'd8,  32'h5555_0008, 1'b1, 1'b0},  // fill bank 5
        '{1'b0, 8'h55, 1'b1, 2'd1, 4'd9,  32'h0,         1'b1, 1'b0},
        '{1'b1, 8'h55, 1'b1, 2'd1, 4'd10, 32'h5555_000a, 1'b1, 1'b0},
        '{1'b0, 8'h55, 1'b1, 2'd1, 4'd11, 32'h0,         1'b1, 1'b0},
        '{1'b1, 8'h55, 1'b1, 2'd1, 4'd12, 32'hbad0_bad0, 1'b1, 1'b1},  // dropped
        '{1'b0, 8'h21, 1'b0, 2'd1, 4'd9,  32'h0,         1'b0, 1'b0},
        '{1'b1, 8'h66, 1'b1, 2'd0, 4'd10, 32'h6666_000a, 1'b0, 1'b0},
        '{1'b0, 8'h77, 1'b1, 2'd2, 4'd11, 32'h0,         1'b0, 1'b0},
        '{1'b0, 8'h78, 1'b1, 2'd2, 4'd12, 32'h0,         1'b0, 1'b0},
        '{1'b1, 8'h33, 1'b0, 2'd3, 4'd13, 32'h3333_000d, 1'b0, 1'b0}
    };

    logic clk_in;
    logic rst_in;
    logic valid_in;
    logic write_in;
    paddr_t addr_in;
    data_t data_in;
    logic cmd_ready;
    logic queue_full;
    logic valid_out;
    dram_cmd_t cmd_out;
    bank_group_t bank_group_out;
    bank_t bank_out;
    row_t row_out;
    col_t col_out;
    data_t data_out;

    // reference model per bank
    mem_request_t model_q [num_banks][$];
    logic model_open [num_banks];
    row_t model_row [num_banks];
    int ready_edge [num_banks];  // last edge on which the bank is still busy

    int seed = 32'h9c86_36e0;
    int edge_cnt = 0;
    logic ready_at_edge = 1'b0;  // cmd_ready as seen by the last rising edge

    request_scheduler dut0 (
        .clk_in(clk_in), .rst_in(rst_in), .valid_in(valid_in), .write_in(write_in),
        .addr_in(addr_in), .data_in(data_in), .cmd_ready(cmd_ready),
        .queue_full(queue_full), .valid_out(valid_out), .cmd_out(cmd_out),
        .bank_group_out(bank_group_out), .bank_out(bank_out), .row_out(row_out),
        .col_out(col_out), .data_out(data_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        edge_cnt      <= edge_cnt + 1;
        ready_at_edge <= cmd_ready;
    end

    initial begin
        #((num_stim * 40 + 200) * clk_period);
        $display("run timed out before all requests were scheduled");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    // waits for the falling edge and checks any command issued on the last rising edge
    task automatic step_and_check();
        int b;
        mem_request_t h;
        @(negedge clk_in);
        if (valid_out) begin
            b = int'(bank_index_t'({bank_group_out, bank_out}));
            assert (ready_at_edge) else report_error("command without cmd_ready");
            assert (model_q[b].size() > 0) else report_error("command to a bank with no work");
            assert (edge_cnt > ready_edge[b]) else report_error("command to a busy bank");
            h = model_q[b][0];
            if (!model_open[b]) begin
                assert (cmd_out == cmd_activate && row_out == h.row)
                    else report_error("expected activate of head row");
                model_open[b] = 1'b1;
                model_row[b]  = h.row;
                ready_edge[b] = edge_cnt + activate_latency;
            end else if (model_row[b] == h.row) begin
                assert (cmd_out == (h.write ? cmd_write : cmd_read) && col_out == h.col)
                    else report_error("wrong access command or column");
                assert (row_out == h.row) else report_error("wrong row on access");
                if (h.write) begin
                    assert (data_out == h.data) else report_error("wrong write data");
                end
                void'(model_q[b].pop_front());
            end else begin
                assert (cmd_out == cmd_precharge) else report_error("expected precharge");
                model_open[b] = 1'b0;
                ready_edge[b] = edge_cnt + precharge_latency;
            end
        end
    endtask

    function automatic logic all_drained();
        for (int b = 0; b < num_banks; b++) begin
            if (model_q[b].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin
        int b;
        mem_request_t r;
        rst_in    = 1'b1;
        valid_in  = 1'b0;
        write_in  = 1'b0;
        addr_in   = '0;
        data_in   = '0;
        cmd_ready = 1'b0;
        for (int i = 0; i < num_banks; i++) begin
            model_open[i] = 1'b0;
            model_row[i]  = '0;
            ready_edge[i] = 0;
        end
        repeat (4) @(negedge clk_in);
        assert (!valid_out && !queue_full) else report_error("outputs not idle after reset");
        assert (cmd_out == cmd_read && {bank_group_out, bank_out} == '0 && row_out == '0)
            else report_error("command fields not cleared by reset");
        assert (col_out == '0 && data_out == '0)
            else report_error("column or data not cleared by reset");
        rst_in = 1'b0;

        for (int i = 0; i < num_stim; i++) begin
            step_and_check();
            r.bank_group = stim_table[i].bg;
            r.bank       = stim_table[i].bank;
            r.row        = stim_table[i].row;
            r.col        = stim_table[i].col;
            r.write      = stim_table[i].wr;
            r.data       = stim_table[i].data;
            valid_in  = 1'b1;
            write_in  = r.write;
            addr_in   = {r.row, r.bank_group, r.bank, r.col};
            data_in   = r.data;
            cmd_ready = stim_table[i].hold ? 1'b0 : 1'($random(seed));
            #1;
            assert (queue_full == stim_table[i].full) else report_error("queue_full mismatch");
            b = int'(bank_index_t'({r.bank_group, r.bank}));
            if (!stim_table[i].full) model_q[b].push_back(r);
        end

        step_and_check();
        valid_in = 1'b0;
        while (!all_drained()) begin
            cmd_ready = 1'($random(seed));
            step_and_check();
        end
        repeat (20) begin  // nothing more may come out
            cmd_ready = 1'($random(seed));
            step_and_check();
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: request_scheduler.f
hdl/sched_geometry_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/bank_status_if.sv
hdl/queue_head_if.sv
hdl/bank_queues.sv
hdl/bank_tracker.sv
hdl/command_picker.sv
hdl/request_scheduler.sv
verification/request_scheduler_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module request_scheduler_tb \
    -f request_scheduler.f -o request_scheduler_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/request_scheduler_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
